//--- galena_pkg.sv
// Galena spin macro definitions

`default_nettype none

package galena_pkg;

    // ========================================
    // Array sizes
    // ========================================
    // Spins and coupling rows
    localparam int NUM_SPIN = 8;

    // Bits per coupling slot on the bit-lines
    localparam int BIT_DATA = 2;

    // Bit-line and word-line widths
    localparam int WBL_WIDTH = NUM_SPIN * BIT_DATA;
    localparam int WWL_WIDTH = NUM_SPIN;

    // Slot bit that carries the spin value during a spin load
    localparam int SPIN_WBL_OFFSET = 0;

    // Signed local field, covers -NUM_SPIN .. +NUM_SPIN
    localparam int FIELD_WIDTH = 5;

    // ========================================
    // Commands
    // ========================================
    // One opcode per cycle, sampled on every clock edge
    typedef enum logic [2:0] {
        OP_IDLE      = 3'd0,
        OP_WRITE_ROW = 3'd1,
        OP_READ_ROW  = 3'd2,
        OP_LOAD_SPIN = 3'd3,
        OP_UPDATE    = 3'd4
    } op_e;

    // ========================================
    // Data types
    // ========================================
    // One bit-line slot, enable sits in bit 0
    typedef struct packed {
        logic negative;
        logic enable;
    } coupling_t;

    // Contents of one word-line, slot j couples to spin j
    typedef coupling_t [NUM_SPIN-1:0] row_t;

    // Result of one synchronous update
    typedef struct packed {
        logic [NUM_SPIN-1:0] spins;
        logic                changed;
    } update_t;

endpackage

`default_nettype wire

//--- coupling_array.sv
// Coupling weight memory

`timescale 1ns/1ps
`default_nettype none

module coupling_array (
    input  logic                               write_spin_i,
    input  logic                               rst_n_i,
    input  galena_pkg::op_e                    op_i,
    input  logic [galena_pkg::WWL_WIDTH-1:0]   wwl_i,
    input  galena_pkg::row_t                   wbl_i,
    output galena_pkg::row_t                   rows_o [galena_pkg::WWL_WIDTH],
    output galena_pkg::row_t                   wbl_read_o,
    output logic [galena_pkg::WBL_WIDTH-1:0]   wblb_read_o,
    output logic                               read_valid_o
);

    import galena_pkg::*;

    logic write_en;
    logic read_en;
    row_t read_merge;

    assign write_en = (op_i == OP_WRITE_ROW);
    assign read_en  = (op_i == OP_READ_ROW);

    // ========================================
    // Row storage
    // ========================================
    // One register per word-line, all rows stay visible to the update unit
    for (genvar i = 0; i < WWL_WIDTH; i++) begin : g_row
        always_ff @(posedge write_spin_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                rows_o[i] <= '0;
            end else if (write_en && wwl_i[i]) begin
                rows_o[i] <= wbl_i;
            end
        end
    end

    // ========================================
    // Readback
    // ========================================
    // OR of every selected row; with a one-hot select this is just that row,
    // with no select it is all zero
    always_comb begin
        read_merge = '0;
        for (int i = 0; i < WWL_WIDTH; i++) begin
            if (wwl_i[i]) begin
                read_merge = read_merge | rows_o[i];
            end
        end
    end

    // Read data holds until the next read command
    always_ff @(posedge write_spin_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wbl_read_o <= '0;
        end else if (read_en) begin
            wbl_read_o <= read_merge;
        end
    end

    // Valid is a single-cycle pulse after each read
    always_ff @(posedge write_spin_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            read_valid_o <= 1'b0;
        end else begin
            read_valid_o <= read_en;
        end
    end

    // Complementary bit-line
    assign wblb_read_o = ~wbl_read_o;

endmodule

`default_nettype wire

//--- spin_register.sv
// Spin vector register

`timescale 1ns/1ps
`default_nettype none

module spin_register (
    input  logic                               write_spin_i,
    input  logic                               rst_n_i,
    input  galena_pkg::op_e                    op_i,
    input  logic [galena_pkg::WBL_WIDTH-1:0]   wbl_i,
    input  galena_pkg::update_t                next_i,
    output logic [galena_pkg::NUM_SPIN-1:0]    spins_o,
    output logic                               settled_o
);

    import galena_pkg::*;

    logic [NUM_SPIN-1:0] load_spins;

    // ========================================
    // Bit-line spin extraction
    // ========================================
    // Spin i rides on one fixed bit of coupling slot i
    always_comb begin
        for (int i = 0; i < NUM_SPIN; i++) begin
            load_spins[i] = wbl_i[BIT_DATA*i + SPIN_WBL_OFFSET];
        end
    end

    // ========================================
    // State
    // ========================================
    always_ff @(posedge write_spin_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            spins_o   <= '0;
            settled_o <= 1'b0;
        end else begin
            case (op_i)
                OP_LOAD_SPIN: begin
                    spins_o   <= load_spins;
                    // A fresh vector has not been relaxed yet
                    settled_o <= 1'b0;
                end
                OP_UPDATE: begin
                    spins_o   <= next_i.spins;
                    // Settled means the last update left every spin alone
                    settled_o <= ~next_i.changed;
                end
                default: begin
                    spins_o   <= spins_o;
                    settled_o <= settled_o;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- spin_update.sv
// Local field and spin decision

`timescale 1ns/1ps
`default_nettype none

module spin_update (
    input  galena_pkg::row_t                   rows_i [galena_pkg::NUM_SPIN],
    input  logic [galena_pkg::NUM_SPIN-1:0]    spins_i,
    output galena_pkg::update_t                next_o
);

    import galena_pkg::*;

    // Per-coupling terms and summed fields, signed
    logic signed [FIELD_WIDTH-1:0] term  [NUM_SPIN][NUM_SPIN];
    logic signed [FIELD_WIDTH-1:0] field [NUM_SPIN];
    logic [NUM_SPIN-1:0]           next_spins;

    // ========================================
    // Coupling terms
    // ========================================
    // Weight times spin is +1 when the spin bit and the negative bit differ,
    // -1 when they match; disabled couplings add nothing
    always_comb begin
        for (int i = 0; i < NUM_SPIN; i++) begin
            for (int j = 0; j < NUM_SPIN; j++) begin
                if (!rows_i[i][j].enable) begin
                    term[i][j] = '0;
                end else if (spins_i[j] ^ rows_i[i][j].negative) begin
                    term[i][j] = {{(FIELD_WIDTH-1){1'b0}}, 1'b1};
                end else begin
                    // Two's complement -1
                    term[i][j] = {FIELD_WIDTH{1'b1}};
                end
            end
        end
    end

    // ========================================
    // Local field sum
    // ========================================
    always_comb begin
        for (int i = 0; i < NUM_SPIN; i++) begin
            field[i] = '0;
            for (int j = 0; j < NUM_SPIN; j++) begin
                field[i] = field[i] + term[i][j];
            end
        end
    end

    // ========================================
    // Sign decision
    // ========================================
    // Positive field -> 1, negative -> 0, zero keeps the old spin
    always_comb begin
        for (int i = 0; i < NUM_SPIN; i++) begin
            if (field[i][FIELD_WIDTH-1]) begin
                next_spins[i] = 1'b0;
            end else if (field[i] != '0) begin
                next_spins[i] = 1'b1;
            end else begin
                next_spins[i] = spins_i[i];
            end
        end
    end

    assign next_o.spins   = next_spins;
    assign next_o.changed = |(next_spins ^ spins_i);

endmodule

`default_nettype wire

//--- galena_core.sv
// Galena spin macro top

`timescale 1ns/1ps
`default_nettype none

module galena_core (
    input  logic                               write_spin_i,
    input  logic                               rst_n_i,
    input  galena_pkg::op_e                    op_i,
    input  logic [galena_pkg::WWL_WIDTH-1:0]   wwl_i,
    input  logic [galena_pkg::WBL_WIDTH-1:0]   wbl_i,
    output logic [galena_pkg::WBL_WIDTH-1:0]   wbl_read_o,
    output logic [galena_pkg::WBL_WIDTH-1:0]   wblb_read_o,
    output logic                               read_valid_o,
    output logic [galena_pkg::NUM_SPIN-1:0]    bct_read_o,
    output logic                               settled_o
);

    import galena_pkg::*;

    row_t    rows [NUM_SPIN];
    update_t next_state;

    // ========================================
    // Coupling memory
    // ========================================
    coupling_array u_coupling_array (
        .write_spin_i (write_spin_i),
        .rst_n_i      (rst_n_i),
        .op_i         (op_i),
        .wwl_i        (wwl_i),
        .wbl_i        (wbl_i),
        .rows_o       (rows),
        .wbl_read_o   (wbl_read_o),
        .wblb_read_o  (wblb_read_o),
        .read_valid_o (read_valid_o)
    );

    // ========================================
    // Spin state
    // ========================================
    spin_register u_spin_register (
        .write_spin_i (write_spin_i),
        .rst_n_i      (rst_n_i),
        .op_i         (op_i),
        .wbl_i        (wbl_i),
        .next_i       (next_state),
        .spins_o      (bct_read_o),
        .settled_o    (settled_o)
    );

    // Next spin vector from all rows and current spins
    spin_update u_spin_update (
        .rows_i  (rows),
        .spins_i (bct_read_o),
        .next_o  (next_state)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// Testbench clock and reset

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 4 ns period
    localparam int HALF_PERIOD_NS = 2;
    localparam int RESET_CYCLES   = 16;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD_NS clk_o = ~clk_o;
    end

    // Release lands on a falling edge, clear of the sampling edge
    initial begin
        rst_n_o = 1'b0;
        #(2 * HALF_PERIOD_NS * RESET_CYCLES);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- galena_tb.sv
// Galena spin macro testbench

`timescale 1ns/1ps
`default_nettype none

module galena_tb;

    import galena_pkg::*;

    localparam int    CLK_PERIOD  = 4;
    localparam int    DRIVE_DELAY = 1;
    localparam string TEST_FILE   = "galena_tests.txt";

    // One line of the test file
    typedef struct packed {
        op_e                  op;
        logic [WWL_WIDTH-1:0] wwl;
        logic [WBL_WIDTH-1:0] wbl;
        logic [NUM_SPIN-1:0]  exp_bct;
        logic [WBL_WIDTH-1:0] exp_rd;
        logic                 exp_valid;
        logic                 exp_settled;
        // Bit 0 spins, bit 1 read data, bit 2 read valid, bit 3 settled
        logic [3:0]           mask;
    } test_vec_t;

    logic                 write_spin;
    logic                 rst_n;
    op_e                  op;
    logic [WWL_WIDTH-1:0] wwl;
    logic [WBL_WIDTH-1:0] wbl;
    logic [WBL_WIDTH-1:0] wbl_read;
    logic [WBL_WIDTH-1:0] wblb_read;
    logic                 read_valid;
    logic [NUM_SPIN-1:0]  bct_read;
    logic                 settled;

    string     name_q [$];
    test_vec_t test_q [$];
    logic      tests_loaded;

    // ========================================
    // DUT and clock
    // ========================================
    tb_clock_gen u_clock_gen (
        .clk_o   (write_spin),
        .rst_n_o (rst_n)
    );

    galena_core u_dut (
        .write_spin_i (write_spin),
        .rst_n_i      (rst_n),
        .op_i         (op),
        .wwl_i        (wwl),
        .wbl_i        (wbl),
        .wbl_read_o   (wbl_read),
        .wblb_read_o  (wblb_read),
        .read_valid_o (read_valid),
        .bct_read_o   (bct_read),
        .settled_o    (settled)
    );

    // ========================================
    // Helpers
    // ========================================
    task automatic load_tests();
        int                   fd;
        int                   cnt;
        int                   ch;
        int                   op_num;
        string                name;
        logic [WWL_WIDTH-1:0] wwl_v;
        logic [WBL_WIDTH-1:0] wbl_v;
        logic [NUM_SPIN-1:0]  bct_v;
        logic [WBL_WIDTH-1:0] rd_v;
        logic                 valid_v;
        logic                 settled_v;
        logic [3:0]           mask_v;
        test_vec_t            vec;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the test file %s", TEST_FILE);
            $display("** FAIL **");
            $fatal(1, "Missing test file");
        end
        forever begin
            cnt = $fscanf(fd, "%s", name);
            if (cnt != 1) begin
                break;
            end
            if (name.getc(0) == "#") begin
                // Comment line, skip to its end
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else begin
                cnt = $fscanf(fd, "%d %h %h %h %h %d %d %h", op_num, wwl_v, wbl_v,
                              bct_v, rd_v, valid_v, settled_v, mask_v);
                if (cnt != 8) begin
                    $display("Test %s has a malformed line in %s", name, TEST_FILE);
                    $display("** FAIL **");
                    $fatal(1, "Bad test file");
                end
                vec.op          = op_e'(op_num[2:0]);
                vec.wwl         = wwl_v;
                vec.wbl         = wbl_v;
                vec.exp_bct     = bct_v;
                vec.exp_rd      = rd_v;
                vec.exp_valid   = valid_v;
                vec.exp_settled = settled_v;
                vec.mask        = mask_v;
                name_q.push_back(name);
                test_q.push_back(vec);
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_inputs(input test_vec_t vec);
        op  = vec.op;
        wwl = vec.wwl;
        wbl = vec.wbl;
    endtask

    task automatic drive_idle();
        op  = OP_IDLE;
        wwl = '0;
        wbl = '0;
    endtask

    task automatic check_value(input string test_name, input string signal_name,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: test %s, %s expected %0h actual %0h",
                     test_name, signal_name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic check_outputs(input int idx);
        test_vec_t            vec;
        string                nm;
        logic [WBL_WIDTH-1:0] exp_rdb;
        vec     = test_q[idx];
        nm      = name_q[idx];
        exp_rdb = ~vec.exp_rd;
        if (vec.mask[0]) begin
            check_value(nm, "bct_read_o", 32'(vec.exp_bct), 32'(bct_read));
        end
        if (vec.mask[1]) begin
            check_value(nm, "wbl_read_o", 32'(vec.exp_rd), 32'(wbl_read));
            check_value(nm, "wblb_read_o", 32'(exp_rdb), 32'(wblb_read));
        end
        if (vec.mask[2]) begin
            check_value(nm, "read_valid_o", 32'(vec.exp_valid), 32'(read_valid));
        end
        if (vec.mask[3]) begin
            check_value(nm, "settled_o", 32'(vec.exp_settled), 32'(settled));
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================
    // Line k is sampled at one edge, its results are checked
    // 1 ns before the edge after, while line k+1 is already driven
    initial begin : main
        int num_tests;
        tests_loaded = 1'b0;
        drive_idle();
        load_tests();
        num_tests    = test_q.size();
        tests_loaded = 1'b1;
        wait (rst_n === 1'b1);
        if (num_tests > 0) begin
            @(posedge write_spin);
            #DRIVE_DELAY;
            drive_inputs(test_q[0]);
            for (int k = 0; k < num_tests; k++) begin
                @(posedge write_spin);
                #DRIVE_DELAY;
                if (k + 1 < num_tests) begin
                    drive_inputs(test_q[k + 1]);
                end else begin
                    drive_idle();
                end
                #(CLK_PERIOD - 2 * DRIVE_DELAY);
                check_outputs(k);
            end
        end
        if (num_tests == 0) begin
            $display("No test lines were found in %s", TEST_FILE);
            $display("** FAIL **");
            $fatal(1, "Empty test file");
        end else begin
            $display("%0d test lines checked", num_tests);
            $display("** PASS **");
            $finish;
        end
    end

    // Watchdog sized from the number of test lines
    initial begin : watchdog
        int limit_ns;
        wait (tests_loaded === 1'b1);
        limit_ns = (test_q.size() + 32) * CLK_PERIOD;
        #(limit_ns);
        $display("Timeout, the run did not finish within %0d ns", limit_ns);
        $display("** FAIL **");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

//--- galena_tests.txt
# name op wwl wbl exp_bct exp_rd exp_valid exp_settled mask (all hex except op, valid, settled)
# op 0 idle 1 write 2 read 3 load 4 update; mask bit 0 spins 1 read data 2 valid 3 settled
reset_state        0 00 0000 00 0000 0 0 f
write_row0         1 01 5554 00 0000 0 0 f
read_row0          2 01 0000 00 5554 1 0 f
read_hold          0 00 0000 00 5554 0 0 f
write_row1         1 02 5551 00 5554 0 0 f
write_row2         1 04 5545 00 5554 0 0 f
write_row3         1 08 5515 00 5554 0 0 f
write_row4         1 10 5455 00 5554 0 0 f
write_row5         1 20 5155 00 5554 0 0 f
write_row6         1 40 4555 00 5554 0 0 f
write_row7         1 80 1555 00 5554 0 0 f
read_row7          2 80 0000 00 1555 1 0 f
read_row3          2 08 0000 00 5515 1 0 f
read_row5          2 20 0000 00 5155 1 0 f
read_none          2 00 0000 00 0000 1 0 f
idle_after_read    0 00 0000 00 0000 0 0 f
load_offset        3 00 aabf 07 0000 0 0 f
update_down        4 00 0000 00 0000 0 0 f
update_down_stable 4 00 0000 00 0000 0 1 f
idle_hold          0 00 ffff 00 0000 0 1 f
load_up            3 00 5540 f8 0000 0 0 f
update_up          4 00 0000 ff 0000 0 0 f
update_up_stable   4 00 0000 ff 0000 0 1 f
idle_settled       0 00 0000 ff 0000 0 1 f
load_clears        3 00 0001 01 0000 0 0 f
write_row0_open    1 01 0000 01 0000 0 0 f
update_zero_field  4 00 0000 01 0000 0 1 f
read_row0_open     2 01 0000 01 0000 1 1 f
write_row0_neg     1 01 000c 01 0000 0 1 f
load_pair          3 00 0005 03 0000 0 0 f
update_neg         4 00 0000 00 0000 0 0 f
update_neg_flip    4 00 0000 01 0000 0 0 f
update_neg_stable  4 00 0000 01 0000 0 1 f
read_row0_neg      2 01 0000 01 000c 1 1 f
read_row1_again    2 02 0000 01 5551 1 1 f
final_idle         0 00 0000 01 5551 0 1 f

//--- galena.f
galena_pkg.sv
coupling_array.sv
spin_register.sv
spin_update.sv
galena_core.sv
tb_clock_gen.sv
galena_tb.sv

//--- Makefile
# Verilator simulation of the Galena spin macro

VERILATOR ?= verilator
TOP       ?= galena_tb
FILELIST  ?= galena.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary -j $(JOBS) --top-module $(TOP) -Mdir $(OBJ_DIR)

FAIL_MSG := ** FAIL **
PASS_MSG := ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Overridable variables: VERILATOR TOP FILELIST OBJ_DIR LOG JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
